// File: sdmac_pkg.sv
// Shared widths, register map, ISTR bit positions, port timing, bus request struct and FSM enums
`default_nettype none

package sdmac_pkg;

    // Bus and register widths
    typedef logic [4:0]  word_addr_t;                  // CPU A6..A2
    typedef logic [31:0] cpu_word_t;                   // CPU data bus
    typedef logic [15:0] pd_word_t;                    // Peripheral data bus
    typedef logic [23:0] wtc_t;                        // Word transfer count
    typedef logic [5:0]  cntr_t;                       // Control register
    typedef logic [7:0]  istr_t;                       // Interrupt status
    typedef logic [1:0]  dawr_t;                       // Data ack width

    // Register word addresses
    localparam word_addr_t ADDR_WTC     = 5'd1;
    localparam word_addr_t ADDR_CNTR    = 5'd2;
    localparam word_addr_t ADDR_DAWR    = 5'd3;
    localparam word_addr_t ADDR_ST_DMA  = 5'd4;        // Strobe, no storage
    localparam word_addr_t ADDR_FLUSH   = 5'd5;        // Strobe, no storage
    localparam word_addr_t ADDR_CLR_INT = 5'd6;        // Strobe, no storage
    localparam word_addr_t ADDR_ISTR    = 5'd7;        // Read only
    localparam word_addr_t ADDR_SP_DMA  = 5'd15;       // Strobe, no storage

    // Peripheral windows, each runs up to the next base
    localparam word_addr_t ADDR_SCSI     = 5'd16;      // Words 16..19
    localparam word_addr_t ADDR_SPARE0   = 5'd20;      // Words 20..21
    localparam word_addr_t ADDR_SPARE1   = 5'd22;      // Words 22..23
    localparam word_addr_t ADDR_PORT_END = 5'd24;      // First word past the ports

    // One-hot port select bit positions
    localparam int PORT_SCSI   = 0;                    // css_n
    localparam int PORT_SPARE0 = 1;                    // csx0_n
    localparam int PORT_SPARE1 = 2;                    // csx1_n

    // Control and status bit positions
    localparam int CNTR_INTEN   = 2;                   // Interrupt output enable
    localparam int ISTR_INT_P   = 0;                   // Pending summary
    localparam int ISTR_INTA    = 1;                   // Latched inta
    localparam int ISTR_INTB    = 2;                   // Latched intb
    localparam int ISTR_DMA_ACT = 3;                   // DMA running

    // Peripheral strobe timing
    localparam int PORT_STROBE_CYCLES = 4;             // Clocks ior_n/iow_n held low
    localparam int PORT_CNT_W = $clog2(PORT_STROBE_CYCLES);

    // Register targeted by the current cycle
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_WTC,
        SEL_CNTR,
        SEL_DAWR,
        SEL_ST_DMA,
        SEL_FLUSH,
        SEL_CLR_INT,
        SEL_ISTR,
        SEL_SP_DMA
    } reg_sel_e;

    // Decoded CPU cycle
    typedef struct packed {
        reg_sel_e   sel;                               // Register hit
        logic [2:0] port;                              // One-hot port hit
        logic       rd;                                // High for read
        logic       ds;                                // Data strobe seen in a selected cycle
    } bus_req_s;

    // Peripheral port FSM
    typedef enum logic [1:0] {
        P_IDLE,
        P_STROBE,
        P_ACK,
        P_WAIT_END
    } port_state_e;

endpackage

`default_nettype wire

// File: sdmac_addr_decode.sv
// Bus cycle decoder producing the register select, port select and peripheral chip selects
`default_nettype none

module sdmac_addr_decode
    import sdmac_pkg::*;
(
    input  logic       cs_n,
    input  logic       as_n,
    input  logic       ds_n,
    input  logic       r_w,
    input  word_addr_t addr,
    output bus_req_s   req,
    output logic       css_n,
    output logic       csx0_n,
    output logic       csx1_n
);

    logic       cycle_act;                             // Chip selected, address valid
    reg_sel_e   sel;
    logic [2:0] port_sel;

    assign cycle_act = !cs_n && !as_n;

    always_comb begin
        sel      = SEL_NONE;
        port_sel = '0;
        if (cycle_act) begin
            // Each window compared on its own
            port_sel[PORT_SCSI]   = (addr >= ADDR_SCSI) && (addr < ADDR_SPARE0);   // WD33C93 window
            port_sel[PORT_SPARE0] = (addr >= ADDR_SPARE0) && (addr < ADDR_SPARE1);
            port_sel[PORT_SPARE1] = (addr >= ADDR_SPARE1) && (addr < ADDR_PORT_END);
            if (port_sel == 3'b000) begin
                case (addr)
                    ADDR_WTC:     sel = SEL_WTC;
                    ADDR_CNTR:    sel = SEL_CNTR;
                    ADDR_DAWR:    sel = SEL_DAWR;
                    ADDR_ST_DMA:  sel = SEL_ST_DMA;
                    ADDR_FLUSH:   sel = SEL_FLUSH;
                    ADDR_CLR_INT: sel = SEL_CLR_INT;
                    ADDR_ISTR:    sel = SEL_ISTR;
                    ADDR_SP_DMA:  sel = SEL_SP_DMA;
                    default:      sel = SEL_NONE;      // Holes ack as registers, read zero
                endcase
            end
        end
    end

    // Request seen by the register block and the port
    assign req.sel  = sel;
    assign req.port = port_sel;
    assign req.rd   = r_w;
    assign req.ds   = cycle_act && !ds_n;              // Only counts inside a selected cycle

    // Active-low chip selects follow the window match
    assign css_n  = !port_sel[PORT_SCSI];
    assign csx0_n = !port_sel[PORT_SPARE0];
    assign csx1_n = !port_sel[PORT_SPARE1];

    // Port windows must not overlap, else two devices fight pd
    assert property (@(negedge ds_n) $onehot0(port_sel))
        else $error("more than one peripheral chip select active");

endmodule

`default_nettype wire

// File: sdmac_regs.sv
// Controller registers, command strobes, interrupt latching and register-cycle acknowledge
`default_nettype none

module sdmac_regs
    import sdmac_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  bus_req_s   req,
    input  logic       as_n,
    input  cpu_word_t  data_in,
    input  logic       inta,
    input  logic       intb,
    output cpu_word_t  reg_rdata,
    output logic [1:0] reg_dsack_n,
    output logic       int_n,
    output logic       dmaen_n,
    output logic       flush
);

    // One-cycle command pulses
    typedef struct packed {
        logic st_dma;
        logic sp_dma;
        logic clr_int;
        logic flush;
    } cmd_s;

    wtc_t  wtc_q;
    cntr_t cntr_q;
    dawr_t dawr_q;
    istr_t istr_q;                                     // Bits INTA, INTB, DMA_ACT stored
    istr_t istr_view;                                  // As seen by the CPU
    cmd_s  cmd_q;
    logic  reg_hit;                                    // ds active on a non-port address
    logic  first_cyc;                                  // Edge flag, first clock of access
    logic  int_p;

    assign reg_hit   = req.ds && (req.port == 3'b000);
    assign first_cyc = reg_hit && (reg_dsack_n == 2'b11);   // Not yet acked

    // 32-bit ack one clock after ds, dropped once as_n is seen high
    always_ff @(posedge sclk) begin
        if (reset) begin
            reg_dsack_n <= 2'b11;
        end else if (as_n) begin
            reg_dsack_n <= 2'b11;                      // Cycle over
        end else if (first_cyc) begin
            reg_dsack_n <= 2'b00;
        end
    end

    // Register writes, once per bus cycle
    always_ff @(posedge sclk) begin
        if (reset) begin
            wtc_q  <= '0;
            cntr_q <= '0;
            dawr_q <= '0;
        end else if (first_cyc && !req.rd) begin
            case (req.sel)
                SEL_WTC:  wtc_q  <= wtc_t'(data_in);   // Upper byte dropped
                SEL_CNTR: cntr_q <= cntr_t'(data_in);
                SEL_DAWR: dawr_q <= dawr_t'(data_in);
                default:  ;                            // ISTR and strobes store nothing
            endcase
        end
    end

    // Command addresses fire on either read or write
    always_ff @(posedge sclk) begin
        if (reset) begin
            cmd_q <= '0;
        end else begin
            cmd_q.st_dma  <= first_cyc && (req.sel == SEL_ST_DMA);
            cmd_q.sp_dma  <= first_cyc && (req.sel == SEL_SP_DMA);
            cmd_q.clr_int <= first_cyc && (req.sel == SEL_CLR_INT);
            cmd_q.flush   <= first_cyc && (req.sel == SEL_FLUSH);
        end
    end

    // Interrupt source latch and DMA active flag
    always_ff @(posedge sclk) begin
        if (reset) begin
            istr_q <= '0;
        end else begin
            // Live source wins over clear
            istr_q[ISTR_INTA] <= inta || (istr_q[ISTR_INTA] && !cmd_q.clr_int);
            istr_q[ISTR_INTB] <= intb || (istr_q[ISTR_INTB] && !cmd_q.clr_int);
            if (cmd_q.st_dma) begin
                istr_q[ISTR_DMA_ACT] <= 1'b1;
            end else if (cmd_q.sp_dma) begin
                istr_q[ISTR_DMA_ACT] <= 1'b0;
            end
        end
    end

    assign int_p = (istr_q[ISTR_INTA] || istr_q[ISTR_INTB]) && cntr_q[CNTR_INTEN];

    always_comb begin
        istr_view             = istr_q;
        istr_view[ISTR_INT_P] = int_p;                 // Summary computed, not stored
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            int_n <= 1'b1;
        end else begin
            int_n <= !int_p;                           // To INT2 on the board
        end
    end

    assign dmaen_n = !istr_q[ISTR_DMA_ACT];            // Enables the address generator
    assign flush   = cmd_q.flush;

    // Read mux, zero-extended; holes and strobes read zero
    always_comb begin
        case (req.sel)
            SEL_WTC:  reg_rdata = cpu_word_t'(wtc_q);
            SEL_CNTR: reg_rdata = cpu_word_t'(cntr_q);
            SEL_DAWR: reg_rdata = cpu_word_t'(dawr_q);
            SEL_ISTR: reg_rdata = cpu_word_t'(istr_view);
            default:  reg_rdata = '0;
        endcase
    end

    // A strobe firing twice would double a DMA start or flush
    assert property (@(posedge sclk) disable iff (reset)
        (cmd_q & $past(cmd_q)) == '0)
        else $error("command pulse longer than one cycle");

    // A peripheral cycle must never see the 32-bit register ack
    assert property (@(posedge sclk) disable iff (reset)
        (req.port != 3'b000) |-> (reg_dsack_n == 2'b11))
        else $error("register dsack during a peripheral cycle");

endmodule

`default_nettype wire

// File: sdmac_io_port.sv
// Peripheral port FSM with strobe timing, 16-bit data movement and port-cycle acknowledge
`default_nettype none

module sdmac_io_port
    import sdmac_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  bus_req_s   req,
    input  logic       as_n,
    input  cpu_word_t  data_in,
    input  pd_word_t   pd_in,
    output cpu_word_t  port_rdata,
    output logic [1:0] port_dsack_n,
    output logic       ior_n,
    output logic       iow_n,
    output pd_word_t   pd_out,
    output logic       pd_oe
);

    port_state_e           state_q;
    logic [PORT_CNT_W-1:0] strobe_cnt_q;               // Clocks of strobe already spent
    pd_word_t              rd_data_q;                  // Captured device data
    logic                  port_hit;
    logic                  strobe_done;

    assign port_hit    = req.ds && (req.port != 3'b000);
    assign strobe_done = (strobe_cnt_q == PORT_CNT_W'(PORT_STROBE_CYCLES - 1));

    always_ff @(posedge sclk) begin
        if (reset) begin
            state_q      <= P_IDLE;
            strobe_cnt_q <= '0;
            ior_n        <= 1'b1;
            iow_n        <= 1'b1;
            pd_oe        <= 1'b0;
            port_dsack_n <= 2'b11;
        end else begin
            case (state_q)
                P_IDLE: begin
                    if (port_hit) begin
                        state_q      <= P_STROBE;
                        strobe_cnt_q <= '0;
                        ior_n        <= !req.rd;       // Read strobe
                        iow_n        <= req.rd;        // Write strobe
                        pd_oe        <= !req.rd;       // Drive pd on writes only
                    end
                end
                P_STROBE: begin
                    if (strobe_done) begin
                        state_q      <= P_ACK;
                        ior_n        <= 1'b1;
                        iow_n        <= 1'b1;
                        port_dsack_n <= 2'b01;         // 16-bit port ack
                    end else begin
                        strobe_cnt_q <= strobe_cnt_q + 1'b1;
                    end
                end
                P_ACK: begin
                    pd_oe <= 1'b0;                     // Write data held one clock past iow_n
                    if (as_n) begin
                        port_dsack_n <= 2'b11;
                        state_q      <= P_IDLE;
                    end else begin
                        state_q <= P_WAIT_END;
                    end
                end
                P_WAIT_END: begin
                    if (as_n) begin                    // CPU released the cycle
                        port_dsack_n <= 2'b11;
                        state_q      <= P_IDLE;
                    end
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge sclk) begin
        if (state_q == P_IDLE && port_hit && !req.rd) begin
            pd_out <= pd_word_t'(data_in);             // Low half of CPU word
        end
        if (state_q == P_STROBE && strobe_done && !ior_n) begin
            rd_data_q <= pd_in;                        // Sampled in last strobe clock
        end
    end

    assign port_rdata = cpu_word_t'(rd_data_q);        // Zero-extended

    // Both strobes low would put the device in an undefined cycle
    assert property (@(posedge sclk) disable iff (reset) !(!ior_n && !iow_n))
        else $error("ior_n and iow_n low together");

endmodule

`default_nettype wire

// File: sdmac_top.sv
// Top level joining decoder, register block and peripheral port, with read mux and ack merge
`default_nettype none

module sdmac_top
    import sdmac_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  logic       cs_n,
    input  logic       as_n,
    input  logic       ds_n,
    input  logic       r_w,
    input  word_addr_t addr,
    input  cpu_word_t  data_in,
    input  logic       inta,
    input  logic       intb,
    input  pd_word_t   pd_in,
    output cpu_word_t  data_out,
    output logic       data_oe,
    output logic [1:0] dsack_n,
    output logic       int_n,
    output logic       dmaen_n,
    output logic       flush,
    output logic       ior_n,
    output logic       iow_n,
    output logic       css_n,
    output logic       csx0_n,
    output logic       csx1_n,
    output pd_word_t   pd_out,
    output logic       pd_oe
);

    bus_req_s   req;
    cpu_word_t  reg_rdata;
    cpu_word_t  port_rdata;
    logic [1:0] reg_dsack_n;
    logic [1:0] port_dsack_n;

    sdmac_addr_decode u_decode (
        .cs_n   (cs_n),
        .as_n   (as_n),
        .ds_n   (ds_n),
        .r_w    (r_w),
        .addr   (addr),
        .req    (req),
        .css_n  (css_n),
        .csx0_n (csx0_n),
        .csx1_n (csx1_n)
    );

    sdmac_regs u_regs (
        .sclk        (sclk),
        .reset       (reset),
        .req         (req),
        .as_n        (as_n),
        .data_in     (data_in),
        .inta        (inta),
        .intb        (intb),
        .reg_rdata   (reg_rdata),
        .reg_dsack_n (reg_dsack_n),
        .int_n       (int_n),
        .dmaen_n     (dmaen_n),
        .flush       (flush)
    );

    sdmac_io_port u_port (
        .sclk         (sclk),
        .reset        (reset),
        .req          (req),
        .as_n         (as_n),
        .data_in      (data_in),
        .pd_in        (pd_in),
        .port_rdata   (port_rdata),
        .port_dsack_n (port_dsack_n),
        .ior_n        (ior_n),
        .iow_n        (iow_n),
        .pd_out       (pd_out),
        .pd_oe        (pd_oe)
    );

    assign data_out = (|req.port) ? port_rdata : reg_rdata;   // Port wins when selected
    assign dsack_n  = reg_dsack_n & port_dsack_n;             // Active-low, either source acks
    assign data_oe  = !cs_n && r_w;                           // Drive CPU bus on reads

endmodule

`default_nettype wire

// File: sdmac_tb.sv
// Testbench with clock, reset, stimulus table, bus cycle task, peripheral model, checks and timeout
`default_nettype none

module sdmac_tb
    import sdmac_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // One table entry: stimulus plus expected response
    typedef struct packed {
        logic       wr;                                // High for write
        word_addr_t addr;
        cpu_word_t  wdata;
        logic       inta;                              // Driven during the cycle
        logic       intb;
        cpu_word_t  exp_rdata;                         // Checked on reads only
        logic [1:0] exp_dsack;
        logic       exp_int_n;                         // Sampled after the cycle
        logic       exp_dmaen_n;
    } row_s;

    localparam logic       RD    = 1'b0;
    localparam logic       WR    = 1'b1;
    localparam logic [1:0] ACK32 = 2'b00;              // Register ack
    localparam logic [1:0] ACK16 = 2'b01;              // Port ack

    logic       sclk;
    logic       reset;
    logic       cs_n;
    logic       as_n;
    logic       ds_n;
    logic       r_w;
    word_addr_t addr;
    cpu_word_t  data_in;
    logic       inta;
    logic       intb;
    pd_word_t   pd_in;
    cpu_word_t  data_out;
    logic       data_oe;
    logic [1:0] dsack_n;
    logic       int_n;
    logic       dmaen_n;
    logic       flush;
    logic       ior_n;
    logic       iow_n;
    logic       css_n;
    logic       csx0_n;
    logic       csx1_n;
    pd_word_t   pd_out;
    logic       pd_oe;

    row_s        rows[$];                              // Stimulus table
    pd_word_t    dev_mem[3];                           // SCSI, spare 0, spare 1
    logic [31:0] lfsr_state;
    int          err_cnt;
    int          flush_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    sdmac_top dut (.*);

    always #5 sclk = ~sclk;                            // 10 ns period

    // Peripheral model, latches on the closing edge of iow_n
    always @(posedge iow_n) begin
        if (!css_n || !csx0_n || !csx1_n) begin
            check_value(32'(pd_oe), 32'd1, "pd_oe at iow_n rise");   // Bus still driven
        end
        if (!css_n) begin
            dev_mem[0] <= pd_out;
        end else if (!csx0_n) begin
            dev_mem[1] <= pd_out;
        end else if (!csx1_n) begin
            dev_mem[2] <= pd_out;
        end
    end

    assign pd_in = !css_n ? dev_mem[0] : !csx0_n ? dev_mem[1] : !csx1_n ? dev_mem[2] : '0;

    always @(negedge sclk) begin
        if (!reset && flush) begin
            flush_cnt++;                               // Counts cycles flush is high
        end
    end

    // Watchdog
    always @(posedge sclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run passed %0d cycles without finishing", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);   // Taps 32,30,26,25
    endfunction

    task automatic rand_word(output cpu_word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[i]       = lfsr_state[0];                // One step per bit
        end
    endtask

    task automatic add_row(input logic wr, input word_addr_t a, input cpu_word_t wd,
                           input logic ia, input logic ib, input cpu_word_t erd,
                           input logic [1:0] eack, input logic eint, input logic edma);
        rows.push_back(row_s'{wr, a, wd, ia, ib, erd, eack, eint, edma});
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // One CPU access; latency counts clocks from ds seen to dsack
    task automatic bus_cycle(input row_s r, output cpu_word_t rdata, output logic [1:0] ack,
                             output logic oe, output int lat);
        @(posedge sclk);
        cs_n    <= 1'b0;
        as_n    <= 1'b0;
        r_w     <= !r.wr;
        addr    <= r.addr;
        data_in <= r.wdata;
        inta    <= r.inta;
        intb    <= r.intb;
        @(posedge sclk);
        ds_n <= 1'b0;
        lat = 0;
        @(negedge sclk);
        while (dsack_n == 2'b11) begin
            @(negedge sclk);
            lat++;
        end
        rdata = data_out;                              // Stable mid-cycle
        ack   = dsack_n;
        oe    = data_oe;
        @(posedge sclk);
        cs_n <= 1'b1;
        as_n <= 1'b1;
        ds_n <= 1'b1;
        inta <= 1'b0;
        intb <= 1'b0;
        repeat (4) @(negedge sclk);                    // Let ack release and status settle
    endtask

    task automatic build_table();
        cpu_word_t rnd_a;
        cpu_word_t rnd_b;
        rand_word(rnd_a);
        rand_word(rnd_b);
        add_row(RD, ADDR_WTC,     '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);     // Reset values
        add_row(RD, ADDR_CNTR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_DAWR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(WR, ADDR_WTC,     rnd_a, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_WTC,     '0, 1'b0, 1'b0, rnd_a & 32'h00FF_FFFF, ACK32, 1'b1, 1'b1);
        add_row(WR, ADDR_CNTR,    rnd_b, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_CNTR,    '0, 1'b0, 1'b0, rnd_b & 32'h0000_003F, ACK32, 1'b1, 1'b1);
        add_row(WR, ADDR_DAWR,    32'hFFFF_FFFF, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_DAWR,    '0, 1'b0, 1'b0, 32'h0000_0003, ACK32, 1'b1, 1'b1);
        add_row(WR, 5'd16,        32'h1234_A5C3, 1'b0, 1'b0, '0, ACK16, 1'b1, 1'b1);  // SCSI
        add_row(RD, 5'd16,        '0, 1'b0, 1'b0, 32'h0000_A5C3, ACK16, 1'b1, 1'b1);
        add_row(WR, 5'd20,        32'hBEEF_5A0F, 1'b0, 1'b0, '0, ACK16, 1'b1, 1'b1);  // Spare 0
        add_row(RD, 5'd21,        '0, 1'b0, 1'b0, 32'h0000_5A0F, ACK16, 1'b1, 1'b1);
        add_row(WR, 5'd22,        32'h0000_C001, 1'b0, 1'b0, '0, ACK16, 1'b1, 1'b1);  // Spare 1
        add_row(RD, 5'd23,        '0, 1'b0, 1'b0, 32'h0000_C001, ACK16, 1'b1, 1'b1);
        add_row(WR, ADDR_CNTR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b1, 1'b0, 32'h0000_0002, ACK32, 1'b1, 1'b1);  // Masked
        add_row(WR, ADDR_CNTR,    32'h0000_0004, 1'b0, 1'b0, '0, ACK32, 1'b0, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b0, 32'h0000_0003, ACK32, 1'b0, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b1, 32'h0000_0007, ACK32, 1'b0, 1'b1);
        add_row(WR, ADDR_CLR_INT, '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(WR, ADDR_ST_DMA,  '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b0);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b0, 32'h0000_0008, ACK32, 1'b1, 1'b0);
        add_row(WR, ADDR_SP_DMA,  '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, ADDR_ISTR,    '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(WR, ADDR_FLUSH,   '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);
        add_row(RD, 5'd9,         '0, 1'b0, 1'b0, '0, ACK32, 1'b1, 1'b1);      // Unmapped
    endtask

    initial begin
        cpu_word_t  rd;
        logic [1:0] ack;
        logic       oe;
        int         lat;
        int         exp_lat;
        int         errs_before;
        int         rows_failed;
        int         idx;
        sclk        = 1'b0;
        reset       = 1'b1;
        cs_n        = 1'b1;
        as_n        = 1'b1;
        ds_n        = 1'b1;
        r_w         = 1'b1;
        addr        = '0;
        data_in     = '0;
        inta        = 1'b0;
        intb        = 1'b0;
        err_cnt     = 0;
        flush_cnt   = 0;
        cycle_cnt   = 0;
        rows_failed = 0;
        lfsr_state  = 32'h2b5aa3e6;
        build_table();
        cycle_limit = 40 * rows.size() + 8;
        repeat (8) @(posedge sclk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            errs_before = err_cnt;
            bus_cycle(rows[i], rd, ack, oe, lat);
            exp_lat = (rows[i].exp_dsack == ACK16) ? PORT_STROBE_CYCLES + 1 : 1;
            check_value(32'(ack), 32'(rows[i].exp_dsack), "dsack_n");
            check_value(32'(lat), 32'(exp_lat), "ack latency");
            check_value(32'(oe), 32'(!rows[i].wr), "data_oe");
            if (!rows[i].wr) begin
                check_value(rd, rows[i].exp_rdata, "read data");
            end else if (rows[i].addr >= ADDR_SCSI && rows[i].addr < ADDR_PORT_END) begin
                idx = (rows[i].addr < ADDR_SPARE0) ? 0 : (rows[i].addr < ADDR_SPARE1) ? 1 : 2;
                check_value(32'(dev_mem[idx]), 32'(rows[i].wdata[15:0]), "peripheral model");
            end
            check_value(32'(dsack_n), 32'(2'b11), "dsack_n release");
            check_value(32'({ior_n, iow_n, pd_oe}), 32'(3'b110), "port strobes idle");
            check_value(32'(int_n), 32'(rows[i].exp_int_n), "int_n");
            check_value(32'(dmaen_n), 32'(rows[i].exp_dmaen_n), "dmaen_n");
            if (err_cnt != errs_before) begin
                rows_failed++;
            end
            $display("Row %0d %s word %0d: %s", i, rows[i].wr ? "write" : "read",
                     rows[i].addr, (err_cnt == errs_before) ? "pass" : "fail");
        end
        check_value(32'(flush_cnt), 32'd1, "flush pulse cycles");
        $display("Rows run %0d, rows failed %0d, errors %0d", rows.size(), rows_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
sdmac_pkg.sv
sdmac_addr_decode.sv
sdmac_regs.sv
sdmac_io_port.sv
sdmac_top.sv
sdmac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the SCSI DMA register interface testbench with Verilator and run it.
# Passes only when the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sdmac_tb -f sim.f -o sdmac_sim \
    && ./obj_dir/sdmac_sim | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
